// ==== include/dram_ctrl_defines.svh ====
`ifndef DRAM_CTRL_DEFINES_SVH
`define DRAM_CTRL_DEFINES_SVH

// burst address, {row, bank, col} on the DDR3 side
`define DRAM_ADDR_W 24

// one burst word, 8 beats of 16 bits
`define DRAM_DATA_W 128

// entries per request queue
// a sender starts with this many credits
`define REQ_FIFO_DEPTH 4

// requests issued to memory but not yet acked
// also sizes the response tag queue
`define MAX_OUTSTANDING 8

`endif

// ==== src/dram_ctrl_pkg.sv ====
`default_nettype none
`include "dram_ctrl_defines.svh"

package dram_ctrl_pkg;

    typedef logic [`DRAM_ADDR_W-1:0] dram_addr_t;
    typedef logic [`DRAM_DATA_W-1:0] dram_data_t;

    // one item of the sample/frame loading path
    typedef struct packed {
        dram_addr_t addr;
        dram_data_t data;
        logic       last;  // final word of a frame
    } write_req_t;

    // who gets the ack of an issued request
    typedef enum logic [1:0] {
        DEST_WRITE = 2'd0,
        DEST_AUDIO = 2'd1,
        DEST_VIDEO = 2'd2
    } rd_dest_t;

endpackage

`default_nettype wire

// ==== src/credit_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "dram_ctrl_defines.svh"

module credit_fifo
    import dram_ctrl_pkg::*;
#(
    parameter type payload_t = dram_addr_t,
    parameter int  DEPTH     = `REQ_FIFO_DEPTH
) (
    input  wire           clk_dram_ctrl,
    input  wire           rst_dram_ctrl,

    input  wire           i_push,
    input  wire payload_t i_push_data,
    input  wire           i_pop,

    output logic          o_not_empty,
    output payload_t      o_head,
    output logic          o_credit
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t           mem [DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic               do_push;
    logic               do_pop;

    // full only if a sender ignores its credits
    assign do_push = i_push && (count != CNT_W'(DEPTH));
    assign do_pop  = i_pop && o_not_empty;

    assign o_not_empty = (count != '0);
    assign o_head      = mem[rd_ptr];  // valid while not empty

    always_ff @(posedge clk_dram_ctrl) begin
        if (do_push) begin
            mem[wr_ptr] <= i_push_data;
        end
    end

    always_ff @(posedge clk_dram_ctrl) begin
        if (rst_dram_ctrl) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            o_credit <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            o_credit <= do_pop;  // one credit back per freed slot
        end
    end

endmodule

`default_nettype wire

// ==== src/traffic_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module traffic_ctrl
    import dram_ctrl_pkg::*;
(
    input  wire             clk_dram_ctrl,
    input  wire             rst_dram_ctrl,

    // request queues
    input  wire             i_vid_pending,
    input  wire dram_addr_t i_vid_addr,
    input  wire             i_aud_pending,
    input  wire dram_addr_t i_aud_addr,
    input  wire             i_wr_pending,
    input  wire write_req_t i_wr_head,
    input  wire             i_tag_full,
    output logic            o_vid_pop,
    output logic            o_aud_pop,
    output logic            o_wr_pop,

    // response router
    output logic            o_tag_push,
    output rd_dest_t        o_tag_dest,
    output logic            o_tag_last,

    // memory request port, stall/ack style
    output logic            o_mem_en,
    output logic            o_mem_we,
    output dram_addr_t      o_mem_addr,
    output dram_data_t      o_mem_wdata,
    input  wire             i_mem_busy
);

    typedef enum logic {
        ST_IDLE,
        ST_ISSUE
    } state_t;

    state_t   state;
    rd_dest_t req_dest;
    logic     req_last;
    logic     any_pending;
    logic     start;
    logic     accept;

    assign any_pending = i_vid_pending | i_aud_pending | i_wr_pending;
    assign start       = (state == ST_IDLE) && any_pending && !i_tag_full;
    assign accept      = (state == ST_ISSUE) && !i_mem_busy;

    always_ff @(posedge clk_dram_ctrl) begin
        if (rst_dram_ctrl) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE:  if (start) state <= ST_ISSUE;
                ST_ISSUE: if (accept) state <= ST_IDLE;  // back to idle so queue heads settle
                default:  state <= ST_IDLE;
            endcase
        end
    end

    // fixed priority, the display must never starve
    always_ff @(posedge clk_dram_ctrl) begin
        if (start) begin
            if (i_vid_pending) begin
                o_mem_addr <= i_vid_addr;
                o_mem_we   <= 1'b0;
                req_dest   <= DEST_VIDEO;
                req_last   <= 1'b0;
            end else if (i_aud_pending) begin
                o_mem_addr <= i_aud_addr;
                o_mem_we   <= 1'b0;
                req_dest   <= DEST_AUDIO;
                req_last   <= 1'b0;
            end else begin
                o_mem_addr  <= i_wr_head.addr;
                o_mem_wdata <= i_wr_head.data;
                o_mem_we    <= 1'b1;
                req_dest    <= DEST_WRITE;
                req_last    <= i_wr_head.last;
            end
        end
    end

    assign o_mem_en = (state == ST_ISSUE);  // fields frozen until accepted

    // acceptance frees the queue slot and books the ack
    assign o_vid_pop  = accept && (req_dest == DEST_VIDEO);
    assign o_aud_pop  = accept && (req_dest == DEST_AUDIO);
    assign o_wr_pop   = accept && (req_dest == DEST_WRITE);
    assign o_tag_push = accept;
    assign o_tag_dest = req_dest;
    assign o_tag_last = req_last;

endmodule

`default_nettype wire

// ==== src/response_router.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "dram_ctrl_defines.svh"

module response_router
    import dram_ctrl_pkg::*;
(
    input  wire             clk_dram_ctrl,
    input  wire             rst_dram_ctrl,

    input  wire             i_tag_push,
    input  wire rd_dest_t   i_tag_dest,
    input  wire             i_tag_last,
    input  wire             i_mem_ack,
    input  wire dram_data_t i_mem_rdata,

    output logic            o_tag_full,
    output logic            o_aud_valid,
    output dram_data_t      o_aud_data,
    output logic            o_vid_valid,
    output dram_data_t      o_vid_data,
    output logic            o_frame_written
);

    localparam int TAG_DEPTH = `MAX_OUTSTANDING;
    localparam int PTR_W     = $clog2(TAG_DEPTH);
    localparam int CNT_W     = $clog2(TAG_DEPTH + 1);

    typedef struct packed {
        rd_dest_t dest;
        logic     last;
    } tag_t;

    tag_t             tags [TAG_DEPTH];
    tag_t             head;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    assign head       = tags[rd_ptr];  // acks come back in issue order
    assign o_tag_full = (count == CNT_W'(TAG_DEPTH));

    always_ff @(posedge clk_dram_ctrl) begin
        if (i_tag_push) begin
            tags[wr_ptr] <= '{dest: i_tag_dest, last: i_tag_last};
        end
        if (i_mem_ack) begin
            o_aud_data <= i_mem_rdata;
            o_vid_data <= i_mem_rdata;
        end
    end

    always_ff @(posedge clk_dram_ctrl) begin
        if (rst_dram_ctrl) begin
            wr_ptr          <= '0;
            rd_ptr          <= '0;
            count           <= '0;
            o_aud_valid     <= 1'b0;
            o_vid_valid     <= 1'b0;
            o_frame_written <= 1'b0;
        end else begin
            wr_ptr <= wr_ptr + PTR_W'(i_tag_push);  // power of two depth wraps itself
            rd_ptr <= rd_ptr + PTR_W'(i_mem_ack);
            count  <= count + CNT_W'(i_tag_push) - CNT_W'(i_mem_ack);

            o_aud_valid <= i_mem_ack && (head.dest == DEST_AUDIO);
            o_vid_valid <= i_mem_ack && (head.dest == DEST_VIDEO);
            if (i_mem_ack && (head.dest == DEST_WRITE) && head.last) begin
                o_frame_written <= 1'b1;  // sticky until reset
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/dram_traffic_top.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "dram_ctrl_defines.svh"

module dram_traffic_top
    import dram_ctrl_pkg::*;
(
    input  wire             clk_dram_ctrl,
    input  wire             rst_dram_ctrl,

    // sample/frame write stream
    input  wire             i_wr_valid,
    input  wire dram_addr_t i_wr_addr,
    input  wire dram_data_t i_wr_data,
    input  wire             i_wr_last,
    output logic            o_wr_credit,

    // read address streams
    input  wire             i_aud_valid,
    input  wire dram_addr_t i_aud_addr,
    output logic            o_aud_credit,
    input  wire             i_vid_valid,
    input  wire dram_addr_t i_vid_addr,
    output logic            o_vid_credit,

    // memory port
    output logic            o_mem_en,
    output logic            o_mem_we,
    output dram_addr_t      o_mem_addr,
    output dram_data_t      o_mem_wdata,
    input  wire             i_mem_busy,
    input  wire             i_mem_ack,
    input  wire dram_data_t i_mem_rdata,

    // read data, no back-pressure
    output logic            o_aud_valid,
    output dram_data_t      o_aud_data,
    output logic            o_vid_valid,
    output dram_data_t      o_vid_data,
    output logic            o_frame_written
);

    write_req_t wr_push_data;
    write_req_t wr_head;
    dram_addr_t aud_head;
    dram_addr_t vid_head;
    logic       wr_pending;
    logic       aud_pending;
    logic       vid_pending;
    logic       wr_pop;
    logic       aud_pop;
    logic       vid_pop;
    logic       tag_push;
    rd_dest_t   tag_dest;
    logic       tag_last;
    logic       tag_full;

    assign wr_push_data = '{addr: i_wr_addr, data: i_wr_data, last: i_wr_last};

    credit_fifo #(
        .payload_t(write_req_t),
        .DEPTH(`REQ_FIFO_DEPTH)
    ) wr_q (
        .clk_dram_ctrl(clk_dram_ctrl),
        .rst_dram_ctrl(rst_dram_ctrl),
        .i_push(i_wr_valid),
        .i_push_data(wr_push_data),
        .i_pop(wr_pop),
        .o_not_empty(wr_pending),
        .o_head(wr_head),
        .o_credit(o_wr_credit)
    );

    credit_fifo #(
        .payload_t(dram_addr_t),
        .DEPTH(`REQ_FIFO_DEPTH)
    ) aud_q (
        .clk_dram_ctrl(clk_dram_ctrl),
        .rst_dram_ctrl(rst_dram_ctrl),
        .i_push(i_aud_valid),
        .i_push_data(i_aud_addr),
        .i_pop(aud_pop),
        .o_not_empty(aud_pending),
        .o_head(aud_head),
        .o_credit(o_aud_credit)
    );

    credit_fifo #(
        .payload_t(dram_addr_t),
        .DEPTH(`REQ_FIFO_DEPTH)
    ) vid_q (
        .clk_dram_ctrl(clk_dram_ctrl),
        .rst_dram_ctrl(rst_dram_ctrl),
        .i_push(i_vid_valid),
        .i_push_data(i_vid_addr),
        .i_pop(vid_pop),
        .o_not_empty(vid_pending),
        .o_head(vid_head),
        .o_credit(o_vid_credit)
    );

    traffic_ctrl tc (
        .clk_dram_ctrl(clk_dram_ctrl),
        .rst_dram_ctrl(rst_dram_ctrl),
        .i_vid_pending(vid_pending),
        .i_vid_addr(vid_head),
        .i_aud_pending(aud_pending),
        .i_aud_addr(aud_head),
        .i_wr_pending(wr_pending),
        .i_wr_head(wr_head),
        .i_tag_full(tag_full),
        .o_vid_pop(vid_pop),
        .o_aud_pop(aud_pop),
        .o_wr_pop(wr_pop),
        .o_tag_push(tag_push),
        .o_tag_dest(tag_dest),
        .o_tag_last(tag_last),
        .o_mem_en(o_mem_en),
        .o_mem_we(o_mem_we),
        .o_mem_addr(o_mem_addr),
        .o_mem_wdata(o_mem_wdata),
        .i_mem_busy(i_mem_busy)
    );

    response_router rr (
        .clk_dram_ctrl(clk_dram_ctrl),
        .rst_dram_ctrl(rst_dram_ctrl),
        .i_tag_push(tag_push),
        .i_tag_dest(tag_dest),
        .i_tag_last(tag_last),
        .i_mem_ack(i_mem_ack),
        .i_mem_rdata(i_mem_rdata),
        .o_tag_full(tag_full),
        .o_aud_valid(o_aud_valid),
        .o_aud_data(o_aud_data),
        .o_vid_valid(o_vid_valid),
        .o_vid_data(o_vid_data),
        .o_frame_written(o_frame_written)
    );

endmodule

`default_nettype wire

// ==== verif/dram_traffic_properties.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "dram_ctrl_defines.svh"

module dram_traffic_properties
    import dram_ctrl_pkg::*;
(
    input wire             clk_dram_ctrl,
    input wire             rst_dram_ctrl,
    input wire             i_wr_valid,
    input wire             o_wr_credit,
    input wire             i_aud_valid,
    input wire             o_aud_credit,
    input wire             i_vid_valid,
    input wire             o_vid_credit,
    input wire             o_mem_en,
    input wire             o_mem_we,
    input wire dram_addr_t o_mem_addr,
    input wire dram_data_t o_mem_wdata,
    input wire             i_mem_busy,
    input wire             o_aud_valid,
    input wire             o_vid_valid,
    input wire             o_frame_written
);

    int wr_cr;
    int aud_cr;
    int vid_cr;
    int reads_open;  // accepted reads with no response pulse yet

    always_ff @(posedge clk_dram_ctrl) begin
        if (rst_dram_ctrl) begin
            wr_cr      <= `REQ_FIFO_DEPTH;
            aud_cr     <= `REQ_FIFO_DEPTH;
            vid_cr     <= `REQ_FIFO_DEPTH;
            reads_open <= 0;
        end else begin
            wr_cr      <= wr_cr - int'(i_wr_valid) + int'(o_wr_credit);
            aud_cr     <= aud_cr - int'(i_aud_valid) + int'(o_aud_credit);
            vid_cr     <= vid_cr - int'(i_vid_valid) + int'(o_vid_credit);
            reads_open <= reads_open + int'(o_mem_en && !i_mem_busy && !o_mem_we)
                          - int'(o_aud_valid || o_vid_valid);
        end
    end

    valid_has_credit: assert property (@(posedge clk_dram_ctrl) disable iff (rst_dram_ctrl)
        (!i_wr_valid || wr_cr > 0) && (!i_aud_valid || aud_cr > 0)
        && (!i_vid_valid || vid_cr > 0)
        && wr_cr <= `REQ_FIFO_DEPTH && aud_cr <= `REQ_FIFO_DEPTH && vid_cr <= `REQ_FIFO_DEPTH)
        else begin
            $error("sender valid without credit, or credits above queue depth");
            tb_dram_traffic.err_cnt++;
        end

    // wdata only matters for writes
    req_stable: assert property (@(posedge clk_dram_ctrl) disable iff (rst_dram_ctrl)
        (o_mem_en && i_mem_busy) |=> (o_mem_en && $stable(o_mem_we) && $stable(o_mem_addr)
        && (!o_mem_we || $stable(o_mem_wdata))))
        else begin
            $error("memory request changed while stalled");
            tb_dram_traffic.err_cnt++;
        end

    resp_expected: assert property (@(posedge clk_dram_ctrl) disable iff (rst_dram_ctrl)
        (o_aud_valid || o_vid_valid) |-> (reads_open > 0 && !(o_aud_valid && o_vid_valid)))
        else begin
            $error("read response pulse with no read outstanding");
            tb_dram_traffic.err_cnt++;
        end

    reset_quiet: assert property (@(posedge clk_dram_ctrl)
        rst_dram_ctrl |=> (!o_mem_en && !o_wr_credit && !o_aud_credit && !o_vid_credit
        && !o_aud_valid && !o_vid_valid && !o_frame_written))
        else begin
            $error("outputs not idle after reset");
            tb_dram_traffic.err_cnt++;
        end

endmodule

`default_nettype wire

// ==== verif/tb_dram_traffic.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "dram_ctrl_defines.svh"

module tb_dram_traffic
    import dram_ctrl_pkg::*;
();

    localparam int DEPTH = `REQ_FIFO_DEPTH;

    logic       clk_dram_ctrl;
    logic       rst_dram_ctrl;
    logic       i_wr_valid;
    dram_addr_t i_wr_addr;
    dram_data_t i_wr_data;
    logic       i_wr_last;
    logic       o_wr_credit;
    logic       i_aud_valid;
    dram_addr_t i_aud_addr;
    logic       o_aud_credit;
    logic       i_vid_valid;
    dram_addr_t i_vid_addr;
    logic       o_vid_credit;
    logic       o_mem_en;
    logic       o_mem_we;
    dram_addr_t o_mem_addr;
    dram_data_t o_mem_wdata;
    logic       i_mem_busy;
    logic       i_mem_ack;
    dram_data_t i_mem_rdata;
    logic       o_aud_valid;
    dram_data_t o_aud_data;
    logic       o_vid_valid;
    dram_data_t o_vid_data;
    logic       o_frame_written;

    int         err_cnt;        // also bumped by the bound assertions
    int         tests_run;
    int         tests_failed;
    int         cyc;
    int         wr_cr;
    int         aud_cr;
    int         vid_cr;
    bit         rand_mode;      // random valids per stream
    bit         busy_en;        // random memory stalls
    bit         last_acked;     // an ack of a last write has been driven
    write_req_t wr_todo[$];
    write_req_t wr_exp[$];
    dram_addr_t aud_todo[$];
    dram_addr_t vid_todo[$];
    dram_data_t aud_exp[$];
    dram_data_t vid_exp[$];
    dram_data_t exp_mem[dram_addr_t];  // what the senders wrote
    dram_data_t stored[dram_addr_t];   // memory model contents
    dram_data_t ack_data[$];
    bit         ack_last[$];
    int         ack_due[$];

    dram_traffic_top dut (.*);

    always #50 clk_dram_ctrl = ~clk_dram_ctrl;

    // never-written words read back as a pattern of their own address
    function automatic dram_data_t expected_word(input dram_addr_t a);
        return exp_mem.exists(a) ? exp_mem[a] : {4{8'hA5, a}};
    endfunction

    task automatic compare_value(input string sig, input logic [127:0] got,
                                 input logic [127:0] want);
        assert (got === want) else begin
            $display("** Error: %s = %h, expected %h", sig, got, want);
            err_cnt++;
        end
    endtask

    task automatic wait_drain(input string what, input int limit);
        int n;
        n = 0;
        @(negedge clk_dram_ctrl);
        while (n < limit && !(wr_todo.size() == 0 && aud_todo.size() == 0
               && vid_todo.size() == 0 && wr_exp.size() == 0 && aud_exp.size() == 0
               && vid_exp.size() == 0 && ack_due.size() == 0 && !o_mem_en)) begin
            @(negedge clk_dram_ctrl);
            n++;
        end
        assert (n < limit) else begin
            $display("timeout: %s traffic did not drain", what);
            err_cnt++;
        end
        repeat (2) @(negedge clk_dram_ctrl);  // frame flag trails the last ack
    endtask

    task automatic end_test(input string name, input int errs_before);
        tests_run++;
        if (err_cnt == errs_before) begin
            $display("test %0d %s: pass", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: FAIL (%0d errors)", tests_run, name, err_cnt - errs_before);
        end
    endtask

    // senders count credits at the edge and drive valids just after it
    always @(posedge clk_dram_ctrl) begin
        bit         live;
        write_req_t w;
        dram_addr_t a;
        live = !rst_dram_ctrl;
        if (!live) begin
            wr_cr = DEPTH;
            aud_cr = DEPTH;
            vid_cr = DEPTH;
        end else begin
            wr_cr += o_wr_credit;
            aud_cr += o_aud_credit;
            vid_cr += o_vid_credit;
            assert (wr_cr <= DEPTH && aud_cr <= DEPTH && vid_cr <= DEPTH) else begin
                $display("a sender got back more credits than the queue depth");
                err_cnt++;
            end
        end
        #10;
        i_wr_valid = 1'b0;
        i_aud_valid = 1'b0;
        i_vid_valid = 1'b0;
        if (live && wr_todo.size() > 0 && wr_cr > 0 && (!rand_mode || $urandom_range(1, 0))) begin
            w = wr_todo.pop_front();
            i_wr_valid = 1'b1;
            i_wr_addr = w.addr;
            i_wr_data = w.data;
            i_wr_last = w.last;
            wr_exp.push_back(w);
            wr_cr--;
        end
        if (live && aud_todo.size() > 0 && aud_cr > 0 && (!rand_mode || $urandom_range(1, 0))) begin
            a = aud_todo.pop_front();
            i_aud_valid = 1'b1;
            i_aud_addr = a;
            aud_exp.push_back(expected_word(a));
            aud_cr--;
        end
        if (live && vid_todo.size() > 0 && vid_cr > 0 && (!rand_mode || $urandom_range(1, 0))) begin
            a = vid_todo.pop_front();
            i_vid_valid = 1'b1;
            i_vid_addr = a;
            vid_exp.push_back(expected_word(a));
            vid_cr--;
        end
    end

    // memory model acks in order 1 to 6 cycles after acceptance
    always @(posedge clk_dram_ctrl) begin
        write_req_t want;
        cyc++;
        if (o_mem_en && !i_mem_busy) begin
            if (o_mem_we) begin
                stored[o_mem_addr] = o_mem_wdata;
                ack_data.push_back('0);
                ack_last.push_back(wr_exp.size() > 0 && wr_exp[0].last);
                assert (wr_exp.size() > 0) else begin
                    $display("memory write accepted with no write pending");
                    err_cnt++;
                end
                if (wr_exp.size() > 0) begin
                    want = wr_exp.pop_front();
                    compare_value("o_mem_addr", o_mem_addr, want.addr);
                    compare_value("o_mem_wdata", o_mem_wdata, want.data);
                end
            end else begin
                ack_data.push_back(stored.exists(o_mem_addr) ? stored[o_mem_addr]
                                                             : {4{8'hA5, o_mem_addr}});
                ack_last.push_back(1'b0);
            end
            ack_due.push_back(cyc + $urandom_range(6, 1));
        end
        #10;
        i_mem_ack = 1'b0;
        if (ack_due.size() > 0 && cyc >= ack_due[0]) begin
            i_mem_ack = 1'b1;
            i_mem_rdata = ack_data.pop_front();
            if (ack_last.pop_front()) begin
                last_acked = 1'b1;
            end
            void'(ack_due.pop_front());
        end
        i_mem_busy = busy_en && ($urandom_range(2, 0) == 0);
    end

    // read responses against the per-stream scoreboards
    always @(posedge clk_dram_ctrl) begin
        if (!rst_dram_ctrl && o_aud_valid) begin
            assert (aud_exp.size() > 0) else begin
                $display("audio response arrived with no audio read outstanding");
                err_cnt++;
            end
            if (aud_exp.size() > 0) compare_value("o_aud_data", o_aud_data, aud_exp.pop_front());
        end
        if (!rst_dram_ctrl && o_vid_valid) begin
            assert (vid_exp.size() > 0) else begin
                $display("video response arrived with no video read outstanding");
                err_cnt++;
            end
            if (vid_exp.size() > 0) compare_value("o_vid_data", o_vid_data, vid_exp.pop_front());
        end
        assert (rst_dram_ctrl || !o_frame_written || last_acked) else begin
            $display("o_frame_written set before the last write was acked");
            err_cnt++;
        end
    end

    initial begin
        int         e;
        write_req_t w;
        void'($urandom(85806));
        clk_dram_ctrl = 1'b0;
        rst_dram_ctrl = 1'b1;
        i_wr_valid = 1'b0;
        i_wr_addr = '0;
        i_wr_data = '0;
        i_wr_last = 1'b0;
        i_aud_valid = 1'b0;
        i_aud_addr = '0;
        i_vid_valid = 1'b0;
        i_vid_addr = '0;
        i_mem_busy = 1'b0;
        i_mem_ack = 1'b0;
        i_mem_rdata = '0;
        rand_mode = 1'b0;
        busy_en = 1'b0;
        last_acked = 1'b0;
        err_cnt = 0;
        tests_run = 0;
        tests_failed = 0;
        cyc = 0;
        repeat (3) @(posedge clk_dram_ctrl);
        #10 rst_dram_ctrl = 1'b0;

        e = err_cnt;
        @(negedge clk_dram_ctrl);
        compare_value("o_mem_en", o_mem_en, 1'b0);
        compare_value("o_wr_credit", o_wr_credit, 1'b0);
        compare_value("o_aud_credit", o_aud_credit, 1'b0);
        compare_value("o_vid_credit", o_vid_credit, 1'b0);
        compare_value("o_aud_valid", o_aud_valid, 1'b0);
        compare_value("o_vid_valid", o_vid_valid, 1'b0);
        compare_value("o_frame_written", o_frame_written, 1'b0);
        end_test("reset state", e);

        e = err_cnt;
        for (int i = 0; i < 8; i++) begin
            w.addr = 24'h000100 + 24'(i);
            w.data = {$urandom, $urandom, $urandom, $urandom};
            w.last = (i == 7);
            exp_mem[w.addr] = w.data;
            wr_todo.push_back(w);
        end
        wait_drain("write burst", 500);
        compare_value("o_frame_written", o_frame_written, 1'b1);
        end_test("write burst", e);

        e = err_cnt;
        for (int i = 0; i < 8; i++) aud_todo.push_back(24'h000100 + 24'(i));
        wait_drain("audio read", 500);
        end_test("audio reads", e);

        e = err_cnt;
        rand_mode = 1'b1;
        busy_en = 1'b1;
        for (int i = 0; i < 12; i++) vid_todo.push_back(24'h000100 + 24'($urandom_range(31, 0)));
        for (int i = 0; i < 8; i++) begin
            aud_todo.push_back(24'h000100 + 24'($urandom_range(31, 0)));
            w.addr = 24'h800000 | 24'($urandom_range(255, 0));  // never read back
            w.data = {$urandom, $urandom, $urandom, $urandom};
            w.last = (i == 7);
            exp_mem[w.addr] = w.data;
            wr_todo.push_back(w);
        end
        wait_drain("mixed", 4000);
        rand_mode = 1'b0;
        busy_en = 1'b0;
        end_test("mixed video traffic", e);

        e = err_cnt;
        compare_value("wr_cr", wr_cr, DEPTH);
        compare_value("aud_cr", aud_cr, DEPTH);
        compare_value("vid_cr", vid_cr, DEPTH);
        end_test("credit accounting", e);

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
        if (err_cnt == 0 && tests_failed == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    bind dram_traffic_top dram_traffic_properties props (.*);

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+include
src/dram_ctrl_pkg.sv
src/credit_fifo.sv
src/traffic_ctrl.sv
src/response_router.sv
src/dram_traffic_top.sv
verif/dram_traffic_properties.sv
verif/tb_dram_traffic.sv
